// ==== common/axi_lite_pkg.sv ====
package axi_lite_pkg;

	// bus geometry of the register slave
	localparam int axi_data_w = 32;
	localparam int axi_strb_w = axi_data_w / 8;
	localparam int axi_addr_w = 4;

	typedef logic [axi_data_w-1:0] axi_data_t;
	typedef logic [axi_strb_w-1:0] axi_strb_t;
	typedef logic [axi_addr_w-1:0] axi_addr_t;

	// word index taken from byte address bits 3..2
	typedef enum logic [1:0] {
		reg_ctrl     = 2'd0,
		reg_user     = 2'd1,
		reg_mem_addr = 2'd2,
		reg_mem_data = 2'd3
	} reg_index_e;

	// only OKAY is ever returned
	localparam logic [1:0] resp_okay = 2'b00;

	// bit of register 0 that holds the processor in reset
	localparam int cpu_reset_bit = 31;

	// drop the byte offset, keep the word index
	function automatic reg_index_e to_index(axi_addr_t addr);
		return reg_index_e'(addr[axi_addr_w-1 -: 2]);
	endfunction

endpackage

// ==== common/mem_pkg.sv ====
package mem_pkg;

	// word memory behind the index 3 window
	localparam int mem_addr_w = 12;
	localparam int mem_depth = 1 << mem_addr_w;
	localparam int mem_word_w = 32;

	// one location and one stored word
	typedef logic [mem_addr_w-1:0] mem_addr_t;
	typedef logic [mem_word_w-1:0] mem_word_t;

endpackage

// ==== common/reg_write_if.sv ====
`timescale 1ns/1ns

// write request from the bus slave into the register block
// valid is a single-cycle strobe, the register block always takes it
interface reg_write_if import axi_lite_pkg::*;;

	logic       valid;
	reg_index_e index;
	axi_data_t  data;
	axi_strb_t  strb;

	// bus side issues the request
	modport source
	(
		output valid,
		output index,
		output data,
		output strb
	);

	// register side consumes it
	modport sink
	(
		input valid,
		input index,
		input data,
		input strb
	);

endinterface

// ==== common/mem_read_if.sv ====
`timescale 1ns/1ns

// read request and returned word between read slave and register block
// req strobes once, index is held until the word has been captured
interface mem_read_if import axi_lite_pkg::*;;

	logic       req;
	reg_index_e index;
	axi_data_t  rdata;

	// read slave side
	modport source
	(
		output req,
		output index,
		input  rdata
	);

	// register block side, rdata is combinational on index
	modport sink
	(
		input  req,
		input  index,
		output rdata
	);

endinterface

// ==== verilog/axi/axi_write_slave.sv ====
`timescale 1ns/1ns

module axi_write_slave import axi_lite_pkg::*;
(
	input  logic        S_AXI_ACLK,
	input  logic        reset_n,
	input  axi_addr_t   awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  axi_data_t   wdata,
	input  axi_strb_t   wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	reg_write_if.source wr
);

	// idle -> accept (ready pulse + strobe) -> resp (hold B until taken)
	typedef enum logic [1:0] {
		wr_idle,
		wr_accept,
		wr_resp
	} wr_state_e;

	wr_state_e  state;
	logic       start;
	reg_index_e index_q;
	axi_data_t  data_q;
	axi_strb_t  strb_q;

	// address and data have to be present together
	assign start = (state == wr_idle) && awvalid && wvalid;

	always_ff @(posedge S_AXI_ACLK or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= wr_idle;
		end
		else
		begin
			case (state)
				wr_idle:
				begin
					if (start)
						state <= wr_accept;
				end
				// single cycle, register gets written on the way out
				wr_accept:
				begin
					state <= wr_resp;
				end
				// back-pressure, nothing new until the response is taken
				wr_resp:
				begin
					if (bready)
						state <= wr_idle;
				end
				default:
				begin
					state <= wr_idle;
				end
			endcase
		end
	end

	// address latched together with the data word
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (start)
		begin
			index_q <= to_index(awaddr);
			data_q  <= wdata;
			strb_q  <= wstrb;
		end
	end

	// both channels handshake in the same cycle
	assign awready = (state == wr_accept);
	assign wready  = (state == wr_accept);

	// response flag is the resp state itself
	assign bvalid = (state == wr_resp);
	assign bresp  = resp_okay;

	// one strobe per transfer
	assign wr.valid = (state == wr_accept);
	assign wr.index = index_q;
	assign wr.data  = data_q;
	assign wr.strb  = strb_q;

endmodule

// ==== verilog/axi/axi_read_slave.sv ====
`timescale 1ns/1ns

module axi_read_slave import axi_lite_pkg::*;
(
	input  logic       S_AXI_ACLK,
	input  logic       reset_n,
	input  axi_addr_t  araddr,
	input  logic       arvalid,
	output logic       arready,
	output axi_data_t  rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  logic       rready,
	mem_read_if.source rd
);

	// idle -> accept (arready + req) -> fetch (wait for word) -> resp
	typedef enum logic [1:0] {
		rd_idle,
		rd_accept,
		rd_fetch,
		rd_resp
	} rd_state_e;

	rd_state_e  state;
	reg_index_e index_q;
	axi_data_t  rdata_q;

	always_ff @(posedge S_AXI_ACLK or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= rd_idle;
		end
		else
		begin
			case (state)
				rd_idle:
				begin
					if (arvalid)
						state <= rd_accept;
				end
				// req goes out in this cycle
				rd_accept:
				begin
					state <= rd_fetch;
				end
				// memory word shows up one cycle after req
				// registers wait as well so both use one path
				rd_fetch:
				begin
					state <= rd_resp;
				end
				// data held stable, no new AR until handshake
				rd_resp:
				begin
					if (rready)
						state <= rd_idle;
				end
				default:
				begin
					state <= rd_idle;
				end
			endcase
		end
	end

	// index kept from acceptance through capture
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (state == rd_idle && arvalid)
			index_q <= to_index(araddr);
	end

	// capture the word at the end of fetch
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (state == rd_fetch)
			rdata_q <= rd.rdata;
	end

	assign arready = (state == rd_accept);

	// rvalid sets when data is loaded and drops on the handshake
	// so each read is returned exactly once
	assign rvalid = (state == rd_resp);
	assign rdata  = rdata_q;
	assign rresp  = resp_okay;

	assign rd.req   = (state == rd_accept);
	assign rd.index = index_q;

endmodule

// ==== verilog/ctrl_regs.sv ====
`timescale 1ns/1ns

module ctrl_regs import axi_lite_pkg::*, mem_pkg::*;
(
	input  logic      S_AXI_ACLK,
	input  logic      reset_n,
	reg_write_if.sink wr,
	mem_read_if.sink  rd,
	output logic      mem_ce,
	output logic      mem_we,
	output mem_addr_t mem_addr,
	output mem_word_t mem_d,
	input  mem_word_t mem_q,
	output logic      cpu_reset_n
);

	axi_data_t ctrl_q;
	axi_data_t user_q;
	mem_addr_t addr_cnt;
	logic      wr_mem;
	logic      rd_mem;

	// replace only the strobed byte lanes
	function automatic axi_data_t merge_bytes(axi_data_t old, axi_data_t data, axi_strb_t strb);
		axi_data_t result;
		result = old;
		for (int i = 0; i < axi_strb_w; i++)
		begin
			if (strb[i])
				result[i*8 +: 8] = data[i*8 +: 8];
		end
		return result;
	endfunction

	// window accesses at index 3
	assign wr_mem = wr.valid && (wr.index == reg_mem_data);
	assign rd_mem = rd.req && (rd.index == reg_mem_data);

	// registers 0 and 1, byte-strobed
	always_ff @(posedge S_AXI_ACLK or negedge reset_n)
	begin
		if (!reset_n)
		begin
			ctrl_q <= '0;
			user_q <= '0;
		end
		else
		begin
			if (wr.valid && wr.index == reg_ctrl)
				ctrl_q <= merge_bytes(ctrl_q, wr.data, wr.strb);
			if (wr.valid && wr.index == reg_user)
				user_q <= merge_bytes(user_q, wr.data, wr.strb);
		end
	end

	// address counter, load ignores strobes and upper data bits
	// post-increment after every window write, reads leave it alone
	always_ff @(posedge S_AXI_ACLK or negedge reset_n)
	begin
		if (!reset_n)
			addr_cnt <= '0;
		else if (wr.valid && wr.index == reg_mem_addr)
			addr_cnt <= wr.data[mem_addr_w-1:0];
		else if (wr_mem)
			addr_cnt <= addr_cnt + 1'b1;
	end

	// processor reset, one cycle behind bit 31 and inverted
	always_ff @(posedge S_AXI_ACLK or negedge reset_n)
	begin
		if (!reset_n)
			cpu_reset_n <= 1'b1;
		else
			cpu_reset_n <= ~ctrl_q[cpu_reset_bit];
	end

	// single port, a write in the same cycle as a window read wins the port
	assign mem_ce   = wr_mem || rd_mem;
	assign mem_we   = wr_mem;
	assign mem_addr = addr_cnt;
	assign mem_d    = wr.data;

	// read mux on the held index
	always_comb
	begin
		case (rd.index)
			reg_ctrl:     rd.rdata = ctrl_q;
			reg_user:     rd.rdata = user_q;
			reg_mem_addr: rd.rdata = {{(axi_data_w - mem_addr_w){1'b0}}, addr_cnt};
			reg_mem_data: rd.rdata = mem_q;
			default:      rd.rdata = '0;
		endcase
	end

endmodule

// ==== verilog/bram_window.sv ====
`timescale 1ns/1ns

module bram_window import mem_pkg::*;
(
	input  logic      S_AXI_ACLK,
	input  logic      mem_ce,
	input  logic      mem_we,
	input  mem_addr_t mem_addr,
	input  mem_word_t mem_d,
	output mem_word_t mem_q
);

	// 4096 words, maps onto block RAM
	mem_word_t mem [mem_depth];

	// write on enable + we, otherwise register the read word
	// q keeps its value between reads
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (mem_ce)
		begin
			if (mem_we)
				mem[mem_addr] <= mem_d;
			else
				mem_q <= mem[mem_addr];
		end
	end

endmodule

// ==== verilog/axi_bram_bridge.sv ====
`timescale 1ns/1ns

module axi_bram_bridge import axi_lite_pkg::*, mem_pkg::*;
(
	input  logic       S_AXI_ACLK,
	input  logic       reset_n,
	// write address channel
	input  axi_addr_t  S_AXI_AWADDR,
	input  logic       S_AXI_AWVALID,
	output logic       S_AXI_AWREADY,
	// write data channel
	input  axi_data_t  S_AXI_WDATA,
	input  axi_strb_t  S_AXI_WSTRB,
	input  logic       S_AXI_WVALID,
	output logic       S_AXI_WREADY,
	// write response channel
	output logic [1:0] S_AXI_BRESP,
	output logic       S_AXI_BVALID,
	input  logic       S_AXI_BREADY,
	// read address channel
	input  axi_addr_t  S_AXI_ARADDR,
	input  logic       S_AXI_ARVALID,
	output logic       S_AXI_ARREADY,
	// read data channel
	output axi_data_t  S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic       S_AXI_RVALID,
	input  logic       S_AXI_RREADY,
	// processor hold, low while reg 0 bit 31 is set
	output logic       cpu_reset_n
);

	// memory port between register block and RAM
	logic      mem_ce;
	logic      mem_we;
	mem_addr_t mem_addr;
	mem_word_t mem_d;
	mem_word_t mem_q;

	reg_write_if wr_if ();
	mem_read_if  rd_if ();

	// AW/W/B side
	axi_write_slave axi_write_slave_i
	(
		.S_AXI_ACLK (S_AXI_ACLK),
		.reset_n    (reset_n),
		.awaddr     (S_AXI_AWADDR),
		.awvalid    (S_AXI_AWVALID),
		.awready    (S_AXI_AWREADY),
		.wdata      (S_AXI_WDATA),
		.wstrb      (S_AXI_WSTRB),
		.wvalid     (S_AXI_WVALID),
		.wready     (S_AXI_WREADY),
		.bresp      (S_AXI_BRESP),
		.bvalid     (S_AXI_BVALID),
		.bready     (S_AXI_BREADY),
		.wr         (wr_if.source)
	);

	// registers, address counter, processor reset
	ctrl_regs ctrl_regs_i
	(
		.S_AXI_ACLK  (S_AXI_ACLK),
		.reset_n     (reset_n),
		.wr          (wr_if.sink),
		.rd          (rd_if.sink),
		.mem_ce      (mem_ce),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_d       (mem_d),
		.mem_q       (mem_q),
		.cpu_reset_n (cpu_reset_n)
	);

	bram_window bram_window_i
	(
		.S_AXI_ACLK (S_AXI_ACLK),
		.mem_ce     (mem_ce),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_d      (mem_d),
		.mem_q      (mem_q)
	);

	// AR/R side
	axi_read_slave axi_read_slave_i
	(
		.S_AXI_ACLK (S_AXI_ACLK),
		.reset_n    (reset_n),
		.araddr     (S_AXI_ARADDR),
		.arvalid    (S_AXI_ARVALID),
		.arready    (S_AXI_ARREADY),
		.rdata      (S_AXI_RDATA),
		.rresp      (S_AXI_RRESP),
		.rvalid     (S_AXI_RVALID),
		.rready     (S_AXI_RREADY),
		.rd         (rd_if.source)
	);

endmodule

// ==== tests/tb_axi_tasks.svh ====
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// compare one value, report and count a mismatch
task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
	if (actual !== expected)
	begin
		$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		errors++;
	end
endtask

// one AW+W transfer, then B with an optional stall of hold cycles
task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
	input logic [3:0] strb, input int hold);
	int count;
	count = 0;
	awaddr  = addr;
	wdata   = data;
	wstrb   = strb;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	// slave answers with both readys in the same cycle
	while (!awready && count < wait_limit)
	begin
		@(negedge S_AXI_ACLK);
		count++;
	end
	if (!awready)
	begin
		$display("timeout: no AWREADY for the write to address %h", addr);
		timeouts++;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		return;
	end
	check_value("S_AXI_WREADY", 32'h1, 32'(wready));
	// handshake happens on the coming rising edge
	@(negedge S_AXI_ACLK);
	awvalid = 1'b0;
	wvalid  = 1'b0;
	count = 0;
	while (!bvalid && count < wait_limit)
	begin
		@(negedge S_AXI_ACLK);
		count++;
	end
	if (!bvalid)
	begin
		$display("timeout: no BVALID for the write to address %h", addr);
		timeouts++;
		return;
	end
	check_value("S_AXI_BRESP", 32'h0, 32'(bresp));
	// master stalls, response must stay up
	for (int i = 0; i < hold; i++)
	begin
		@(negedge S_AXI_ACLK);
		check_value("S_AXI_BVALID", 32'h1, 32'(bvalid));
	end
	bready = 1'b1;
	@(negedge S_AXI_ACLK);
	bready = 1'b0;
	check_value("S_AXI_BVALID", 32'h0, 32'(bvalid));
endtask

// one AR transfer, then R with an optional stall, returns the word
task automatic axi_read(input logic [3:0] addr, input int hold, output logic [31:0] data);
	int count;
	logic [31:0] first;
	data = '0;
	count = 0;
	araddr  = addr;
	arvalid = 1'b1;
	while (!arready && count < wait_limit)
	begin
		@(negedge S_AXI_ACLK);
		count++;
	end
	if (!arready)
	begin
		$display("timeout: no ARREADY for the read of address %h", addr);
		timeouts++;
		arvalid = 1'b0;
		return;
	end
	@(negedge S_AXI_ACLK);
	arvalid = 1'b0;
	count = 0;
	while (!rvalid && count < wait_limit)
	begin
		@(negedge S_AXI_ACLK);
		count++;
	end
	if (!rvalid)
	begin
		$display("timeout: no RVALID for the read of address %h", addr);
		timeouts++;
		return;
	end
	check_value("S_AXI_RRESP", 32'h0, 32'(rresp));
	first = rdata;
	// data has to hold still while rready is low
	for (int i = 0; i < hold; i++)
	begin
		@(negedge S_AXI_ACLK);
		check_value("S_AXI_RVALID", 32'h1, 32'(rvalid));
		check_value("S_AXI_RDATA stable", first, rdata);
	end
	data = rdata;
	rready = 1'b1;
	@(negedge S_AXI_ACLK);
	rready = 1'b0;
	// a read is returned once only
	check_value("S_AXI_RVALID", 32'h0, 32'(rvalid));
endtask

`endif

// ==== tests/tb_axi_bram_bridge.sv ====
`timescale 1ns/1ns

module tb_axi_bram_bridge;

	// row kinds of the stimulus table
	localparam logic [1:0] op_write = 2'd0;
	localparam logic [1:0] op_read  = 2'd1;
	localparam logic [1:0] op_poll  = 2'd2;
	localparam int wait_limit = 16;

	// one table row per operation
	// a poll row takes its level from expect_val bit 0
	typedef struct packed {
		logic [1:0]  kind;
		logic [3:0]  addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] expect_val;
		logic [3:0]  hold;
	} op_t;

	logic        S_AXI_ACLK;
	logic        reset_n;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        cpu_reset_n;

	int          errors;
	int          timeouts;
	integer      seed;
	op_t         ops[$];
	op_t         op;
	logic [31:0] rd_word;

	`include "tb_axi_tasks.svh"

	axi_bram_bridge axi_bram_bridge_i
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.reset_n       (reset_n),
		.S_AXI_AWADDR  (awaddr),
		.S_AXI_AWVALID (awvalid),
		.S_AXI_AWREADY (awready),
		.S_AXI_WDATA   (wdata),
		.S_AXI_WSTRB   (wstrb),
		.S_AXI_WVALID  (wvalid),
		.S_AXI_WREADY  (wready),
		.S_AXI_BRESP   (bresp),
		.S_AXI_BVALID  (bvalid),
		.S_AXI_BREADY  (bready),
		.S_AXI_ARADDR  (araddr),
		.S_AXI_ARVALID (arvalid),
		.S_AXI_ARREADY (arready),
		.S_AXI_RDATA   (rdata),
		.S_AXI_RRESP   (rresp),
		.S_AXI_RVALID  (rvalid),
		.S_AXI_RREADY  (rready),
		.cpu_reset_n   (cpu_reset_n)
	);

	// 100 ns period
	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #50 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// old word with every strobed byte lane taken from data
	function automatic logic [31:0] apply_strobe(logic [31:0] old, logic [31:0] data,
		logic [3:0] strb);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old & ~mask) | (data & mask);
	endfunction

	function void push_write(logic [3:0] addr, logic [31:0] data, logic [3:0] strb, int hold);
		ops.push_back({op_write, addr, data, strb, 32'h0, 4'(hold)});
	endfunction

	function void push_read(logic [3:0] addr, logic [31:0] expect_val, int hold);
		ops.push_back({op_read, addr, 32'h0, 4'h0, expect_val, 4'(hold)});
	endfunction

	function void push_poll(logic level);
		ops.push_back({op_poll, 4'h0, 32'h0, 4'h0, 32'(level), 4'h0});
	endfunction

	// table with expected values from the register rules
	task build_table();
		logic [31:0] user_val;
		logic [31:0] word;
		logic [3:0]  strb;
		logic [11:0] start_addr;
		logic [31:0] words [0:4];
		user_val = 32'h0;
		// everything cleared out of reset
		push_read(4'h0, 32'h0, 0);
		push_read(4'h4, 32'h0, 0);
		push_read(4'h8, 32'h0, 0);
		// byte lanes of register 1 merge with the old value
		word = $random(seed);
		push_write(4'h4, word, 4'hf, 0);
		user_val = word;
		push_read(4'h4, user_val, 0);
		for (int i = 0; i < 4; i++)
		begin
			word = $random(seed);
			strb = 4'($random(seed));
			push_write(4'h4, word, strb, 0);
			user_val = apply_strobe(user_val, word, strb);
			push_read(4'h4, user_val, 0);
		end
		// processor hold via bit 31
		push_write(4'h0, 32'h8000_0000, 4'hf, 0);
		push_poll(1'b0);
		push_read(4'h0, 32'h8000_0000, 0);
		// releasing it needs only the top byte lane
		push_write(4'h0, 32'h0, 4'b1000, 0);
		push_poll(1'b1);
		// fill the window from a random start address
		// index 2 ignores upper data bits and strobes
		start_addr = 12'($random(seed));
		word = $random(seed);
		push_write(4'h8, {word[31:12], start_addr}, 4'b0001, 0);
		for (int k = 0; k < 5; k++)
		begin
			words[k] = $random(seed);
			push_write(4'hc, words[k], 4'hf, 0);
		end
		push_read(4'h8, {20'h0, start_addr + 12'd5}, 0);
		// rewinding and reading must not move the address
		push_write(4'h8, {20'h0, start_addr}, 4'hf, 0);
		push_read(4'hc, words[0], 0);
		push_read(4'hc, words[0], 0);
		word = $random(seed);
		push_write(4'hc, word, 4'hf, 0);
		push_read(4'hc, words[1], 0);
		push_read(4'h8, {20'h0, start_addr + 12'd1}, 0);
		// stalled responses
		word = $random(seed);
		push_write(4'h4, word, 4'hf, 5);
		user_val = word;
		push_read(4'h4, user_val, 5);
		push_read(4'hc, words[1], 3);
	endtask

	// cpu_reset_n settles a cycle after the register
	task automatic wait_cpu_reset(input logic level);
		int count;
		count = 0;
		while (cpu_reset_n !== level && count < wait_limit)
		begin
			@(negedge S_AXI_ACLK);
			count++;
		end
		if (cpu_reset_n !== level)
		begin
			$display("timeout: cpu_reset_n did not go to %0d", level);
			timeouts++;
		end
	endtask

	initial
	begin
		reset_n  = 1'b0;
		awaddr   = 4'h0;
		awvalid  = 1'b0;
		wdata    = 32'h0;
		wstrb    = 4'h0;
		wvalid   = 1'b0;
		bready   = 1'b0;
		araddr   = 4'h0;
		arvalid  = 1'b0;
		rready   = 1'b0;
		errors   = 0;
		timeouts = 0;
		seed     = 32'hd5b6_5dac;
		build_table();
		// two cycles in reset before release on a falling edge
		repeat (2) @(negedge S_AXI_ACLK);
		// processor runs while the bridge is held in reset
		check_value("cpu_reset_n", 32'h1, 32'(cpu_reset_n));
		reset_n = 1'b1;
		@(negedge S_AXI_ACLK);
		for (int i = 0; i < ops.size(); i++)
		begin
			op = ops[i];
			case (op.kind)
				op_write:
				begin
					axi_write(op.addr, op.data, op.strb, int'(op.hold));
				end
				op_read:
				begin
					axi_read(op.addr, int'(op.hold), rd_word);
					check_value($sformatf("S_AXI_RDATA at %h", op.addr), op.expect_val, rd_word);
				end
				default:
				begin
					wait_cpu_reset(op.expect_val[0]);
				end
			endcase
		end
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== axi_bram_bridge.f ====
+incdir+tests
common/axi_lite_pkg.sv
common/mem_pkg.sv
common/reg_write_if.sv
common/mem_read_if.sv
verilog/axi/axi_write_slave.sv
verilog/axi/axi_read_slave.sv
verilog/ctrl_regs.sv
verilog/bram_window.sv
verilog/axi_bram_bridge.sv
tests/tb_axi_bram_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_axi_bram_bridge \
	-f axi_bram_bridge.f \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
